// ==== Makefile ====
# Verilator build and run for the copy engine testbench
TOP = tb_copy_engine

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_copy_engine.sv ====
// Self-checking testbench for the strided copy engine
// Keeps a shadow of the SRAM, predicts copies with an AGU reference function
// and checks every host read response against the shadow
`default_nettype none
`include "agu_consts.svh"

module tb_copy_engine;

  localparam int N_HOST    = 32;
  localparam int N_LIN     = 64;
  localparam int N_2D      = 48;
  localparam int N_NEG     = 40;
  localparam int N_CONT    = 64;
  localparam int N_RESTART = 64;
  localparam int WATCHDOG_CYCLES =
    40 * (N_HOST + N_LIN + N_2D + N_NEG + N_CONT + N_RESTART) + 2000;

  logic                          clk, rst, start;
  logic [`ADDR_W:0]              xfer_count;
  logic [`ADDR_W-1:0]            rd_base, wr_base;
  logic [4:1][`LEN_W-1:0]        rd_len, wr_len;   // Index 1 is l1
  logic [4:0][`ADDR_W-1:0]       rd_jmp, wr_jmp;   // Index 0 is j0
  logic                          host_req_valid, host_req_ready, host_rsp_valid;
  mem_pkg::mem_op_e              host_req_op;
  logic [`ADDR_W-1:0]            host_req_addr;
  logic [`DATA_W-1:0]            host_req_wdata, host_rsp_data;
  logic                          busy, done;

  logic [`DATA_W-1:0] shadow [`MEM_DEPTH];  // Expected SRAM contents
  logic [`DATA_W-1:0] exp_q [$];            // Outstanding host reads
  string              test_name;
  logic               copy_running;

  copy_engine_top uut (
    .clk (clk), .rst (rst), .start (start), .xfer_count (xfer_count),
    .rd_base (rd_base), .rd_l1 (rd_len[1]), .rd_l2 (rd_len[2]),
    .rd_l3 (rd_len[3]), .rd_l4 (rd_len[4]), .rd_j0 (rd_jmp[0]),
    .rd_j1 (rd_jmp[1]), .rd_j2 (rd_jmp[2]), .rd_j3 (rd_jmp[3]), .rd_j4 (rd_jmp[4]),
    .wr_base (wr_base), .wr_l1 (wr_len[1]), .wr_l2 (wr_len[2]),
    .wr_l3 (wr_len[3]), .wr_l4 (wr_len[4]), .wr_j0 (wr_jmp[0]),
    .wr_j1 (wr_jmp[1]), .wr_j2 (wr_jmp[2]), .wr_j3 (wr_jmp[3]), .wr_j4 (wr_jmp[4]),
    .host_req_valid (host_req_valid), .host_req_ready (host_req_ready),
    .host_req_op (host_req_op), .host_req_addr (host_req_addr),
    .host_req_wdata (host_req_wdata), .host_rsp_valid (host_rsp_valid),
    .host_rsp_data (host_rsp_data), .busy (busy), .done (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  // k-th address after clr where the deepest running loop jumps and deeper loops restart
  function automatic logic [`ADDR_W-1:0] agu_ref(input logic [4:1][`LEN_W-1:0] len,
                                                 input logic [4:0][`ADDR_W-1:0] jmp,
                                                 input int k);
    logic [`LEN_W-1:0]  cnt [1:4];
    logic [`ADDR_W-1:0] a;
    agu_pkg::loop_lvl_e lvl;
    a = '0;
    for (int d = 1; d <= 4; d++) cnt[d] = len[d];
    repeat (k) begin
      lvl = agu_pkg::LVL_J0;                      // Outer loop when all counters zero
      for (int d = 1; d <= 4; d++) begin
        if (cnt[d] != '0) lvl = agu_pkg::loop_lvl_e'(d);
      end
      a = a + jmp[int'(lvl)];                     // Wraps at 2**ADDR_W
      if (lvl != agu_pkg::LVL_J0) cnt[int'(lvl)] = cnt[int'(lvl)] - 1'b1;
      for (int d = int'(lvl) + 1; d <= 4; d++) cnt[d] = len[d];
    end
    return a;
  endfunction

  // Called at posedge+2 and returns at posedge+2 after acceptance
  task automatic host_access(input mem_pkg::mem_op_e op, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] wdata);
    logic taken;
    host_req_valid = 1'b1;
    host_req_op    = op;
    host_req_addr  = addr;
    host_req_wdata = wdata;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = host_req_ready;                     // Stable mid-cycle
      @(posedge clk);
      #2;
    end
    host_req_valid = 1'b0;
  endtask

  task automatic host_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    shadow[addr] = data;
    host_access(mem_pkg::OP_WRITE, addr, data);
  endtask

  task automatic host_read(input logic [`ADDR_W-1:0] addr);
    exp_q.push_back(shadow[addr]);                // Expected word in issue order
    host_access(mem_pkg::OP_READ, addr, '0);
  endtask

  task automatic fill_region(input logic [`ADDR_W-1:0] base, input int n);
    for (int k = 0; k < n; k++) host_write(base + k[`ADDR_W-1:0], $urandom);
  endtask

  task automatic check_region(input logic [`ADDR_W-1:0] base, input int n);
    for (int k = 0; k < n; k++) host_read(base + k[`ADDR_W-1:0]);
  endtask

  // Initialize every word the reader will touch
  task automatic fill_source(input int n, input logic [`ADDR_W-1:0] src);
    for (int k = 0; k < n; k++) host_write(src + agu_ref(rd_len, rd_jmp, k), $urandom);
  endtask

  task automatic verify_copy(input int n, input logic [`ADDR_W-1:0] dst);
    for (int k = 0; k < n; k++) host_read(dst + agu_ref(wr_len, wr_jmp, k));
  endtask

  task automatic set_linear();
    rd_len = '0;
    wr_len = '0;
    rd_jmp = '0;
    wr_jmp = '0;
    rd_jmp[0] = 10'd1;
    wr_jmp[0] = 10'd1;
  endtask

  // restart_at > 0 pulses start again that many cycles into the copy
  task automatic run_copy(input int n, input logic [`ADDR_W-1:0] src,
                          input logic [`ADDR_W-1:0] dst, input int restart_at);
    logic [`DATA_W-1:0] vals [$];
    logic               seen;
    int                 cyc;
    for (int k = 0; k < n; k++) vals.push_back(shadow[src + agu_ref(rd_len, rd_jmp, k)]);
    for (int k = 0; k < n; k++) shadow[dst + agu_ref(wr_len, wr_jmp, k)] = vals[k];
    xfer_count = n[`ADDR_W:0];
    rd_base    = src;
    wr_base    = dst;
    start      = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    seen  = 1'b0;
    cyc   = 0;
    while (!seen) begin
      @(negedge clk);
      seen = done;
      if (cyc == 0 && n > 0) assert (busy) else abort_run("busy did not rise after start");
      if (seen) assert (!busy) else abort_run("busy still high while done pulsed");
      @(posedge clk);
      #2;
      cyc++;
      start = (cyc == restart_at);
      if (start) xfer_count = 11'd3;              // Must be ignored mid-copy
    end
    start = 1'b0;
  endtask

  task automatic host_traffic(input logic [`ADDR_W-1:0] base, input int n);
    while (copy_running) begin
      repeat ($urandom_range(0, 3)) begin
        @(posedge clk);
        #2;
      end
      host_read(base + 10'($urandom_range(0, n - 1)));
    end
  endtask

  // Response checker
  initial begin
    logic [`DATA_W-1:0] exp_word;
    forever begin
      @(negedge clk);
      if (host_rsp_valid) begin
        assert (exp_q.size() > 0) else abort_run("host response with no read outstanding");
        exp_word = exp_q.pop_front();
        assert (host_rsp_data == exp_word) else
          abort_run($sformatf("ERROR %s expected %h actual %h",
                              test_name, exp_word, host_rsp_data));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the copy engine did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst            = 1'b1;
    start          = 1'b0;
    xfer_count     = '0;
    rd_base        = '0;
    wr_base        = '0;
    host_req_valid = 1'b0;
    host_req_op    = mem_pkg::OP_READ;
    host_req_addr  = '0;
    host_req_wdata = '0;
    copy_running   = 1'b0;
    set_linear();
    void'($urandom(32'h5353));
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    test_name = "host_rw";
    fill_region(10'h300, N_HOST);
    check_region(10'h300, N_HOST);

    test_name = "linear";
    fill_region(10'h000, N_LIN);
    run_copy(N_LIN, 10'h000, 10'h100, 0);
    verify_copy(N_LIN, 10'h100);

    test_name = "strided_2d";                     // 4x4 blocks with pitch 16
    rd_len[4] = 4'd3;
    rd_len[3] = 4'd3;
    rd_len[2] = 4'd1;
    rd_jmp[4] = 10'd1;
    rd_jmp[3] = 10'd13;
    rd_jmp[2] = 10'd40;
    rd_jmp[0] = 10'd5;
    fill_source(N_2D, 10'h200);
    run_copy(N_2D, 10'h200, 10'h340, 0);
    verify_copy(N_2D, 10'h340);

    test_name = "negative_wrap";                  // Walks down through address zero
    set_linear();
    rd_len[4] = 4'd15;
    rd_len[3] = 4'd1;
    rd_jmp[4] = -10'sd3;
    rd_jmp[3] = -10'sd2;
    rd_jmp[0] = -10'sd1;
    fill_source(N_NEG, 10'h010);
    run_copy(N_NEG, 10'h010, 10'h080, 0);
    verify_copy(N_NEG, 10'h080);

    test_name = "contention";
    set_linear();
    fill_region(10'h0c0, 64);                     // Host-only region
    fill_region(10'h140, N_CONT);
    copy_running = 1'b1;
    fork
      begin
        run_copy(N_CONT, 10'h140, 10'h180, 0);
        copy_running = 1'b0;
      end
      host_traffic(10'h0c0, 64);
    join
    verify_copy(N_CONT, 10'h180);

    test_name = "zero_length";                    // Source differs from the destination
    run_copy(0, 10'h300, 10'h100, 0);
    check_region(10'h100, N_LIN);

    test_name = "start_while_busy";
    run_copy(N_RESTART, 10'h000, 10'h1c0, 10);
    verify_copy(N_RESTART, 10'h1c0);

    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run("host reads left without a response");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/agu_pkg.sv
src/mem_pkg.sv
src/agu.sv
src/sram_sp.sv
src/mem_arbiter.sv
src/stream_reader.sv
src/stream_writer.sv
src/copy_engine_top.sv
dv/tb_copy_engine.sv

// ==== src/agu.sv ====
// Nested-loop address generator with four counted loops inside an endless outer loop
// addr is valid every cycle and advances by one jump on each step
`default_nettype none
`include "agu_consts.svh"

module agu (
  input  logic               clk,
  input  logic               rst,
  input  logic               clr,   // Reload lengths, zero the address
  input  logic               step,  // Advance one address
  input  logic [`LEN_W-1:0]  l1,
  input  logic [`LEN_W-1:0]  l2,
  input  logic [`LEN_W-1:0]  l3,
  input  logic [`LEN_W-1:0]  l4,
  input  logic [`ADDR_W-1:0] j0,    // Signed two's complement jumps
  input  logic [`ADDR_W-1:0] j1,
  input  logic [`ADDR_W-1:0] j2,
  input  logic [`ADDR_W-1:0] j3,
  input  logic [`ADDR_W-1:0] j4,
  output logic [`ADDR_W-1:0] addr
);

  logic [`LEN_W-1:0]  i1, i2, i3, i4;  // Loop down-counters
  agu_pkg::loop_lvl_e lvl;             // Level taken by the next step
  logic [`ADDR_W-1:0] jump;

  // Deepest loop still running owns the step
  always_comb begin
    if (i4 != '0) lvl = agu_pkg::LVL_J4;
    else if (i3 != '0) lvl = agu_pkg::LVL_J3;
    else if (i2 != '0) lvl = agu_pkg::LVL_J2;
    else if (i1 != '0) lvl = agu_pkg::LVL_J1;
    else lvl = agu_pkg::LVL_J0;         // All loops done
  end

  always_comb begin
    case (lvl)
      agu_pkg::LVL_J4: jump = j4;
      agu_pkg::LVL_J3: jump = j3;
      agu_pkg::LVL_J2: jump = j2;
      agu_pkg::LVL_J1: jump = j1;
      default:         jump = j0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
      i1   <= '0;                       // Zero counters so first step takes j0
      i2   <= '0;
      i3   <= '0;
      i4   <= '0;
    end else if (clr) begin
      addr <= '0;
      i1   <= l1;
      i2   <= l2;
      i3   <= l3;
      i4   <= l4;
    end else if (step) begin
      addr <= addr + jump;              // Wraps modulo address space
      case (lvl)
        agu_pkg::LVL_J4: i4 <= i4 - 1'b1;
        agu_pkg::LVL_J3: begin
          i3 <= i3 - 1'b1;
          i4 <= l4;                     // Restart inner loop
        end
        agu_pkg::LVL_J2: begin
          i2 <= i2 - 1'b1;
          i3 <= l3;
          i4 <= l4;
        end
        agu_pkg::LVL_J1: begin
          i1 <= i1 - 1'b1;
          i2 <= l2;
          i3 <= l3;
          i4 <= l4;
        end
        default: begin                  // Outer wrap reloads everything
          i1 <= l1;
          i2 <= l2;
          i3 <= l3;
          i4 <= l4;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/agu_consts.svh ====
// Width and depth constants shared by the copy engine RTL and testbench
// Include wherever a bus or memory is sized
`ifndef AGU_CONSTS_SVH
`define AGU_CONSTS_SVH

// Word address width; address math wraps at 2**ADDR_W
`define ADDR_W 10

// Loop length counter width
`define LEN_W 4

// Data word width
`define DATA_W 16

// SRAM size in words, matches the full address space
`define MEM_DEPTH 1024

`endif

// ==== src/agu_pkg.sv ====
// Types describing address patterns and copy progress
// Referenced by scoped name from the AGU, the stream peers and the testbench
`default_nettype none

package agu_pkg;

  // Jump applied by one AGU step in outermost-first order
  typedef enum logic [2:0] {
    LVL_J0,  // Outer loop wrap
    LVL_J1,
    LVL_J2,
    LVL_J3,
    LVL_J4   // Innermost loop
  } loop_lvl_e;

  // Reader and writer controller state
  typedef enum logic {
    CP_IDLE,
    CP_RUN
  } copy_state_e;

endpackage

`default_nettype wire

// ==== src/copy_engine_top.sv ====
// Strided copy engine top where reader, writer and host share one SRAM
// through the round-robin arbiter; start launches a copy and done ends it
`default_nettype none
`include "agu_consts.svh"

module copy_engine_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic [`ADDR_W:0]   xfer_count,
  input  logic [`ADDR_W-1:0] rd_base,
  input  logic [`LEN_W-1:0]  rd_l1,
  input  logic [`LEN_W-1:0]  rd_l2,
  input  logic [`LEN_W-1:0]  rd_l3,
  input  logic [`LEN_W-1:0]  rd_l4,
  input  logic [`ADDR_W-1:0] rd_j0,
  input  logic [`ADDR_W-1:0] rd_j1,
  input  logic [`ADDR_W-1:0] rd_j2,
  input  logic [`ADDR_W-1:0] rd_j3,
  input  logic [`ADDR_W-1:0] rd_j4,
  input  logic [`ADDR_W-1:0] wr_base,
  input  logic [`LEN_W-1:0]  wr_l1,
  input  logic [`LEN_W-1:0]  wr_l2,
  input  logic [`LEN_W-1:0]  wr_l3,
  input  logic [`LEN_W-1:0]  wr_l4,
  input  logic [`ADDR_W-1:0] wr_j0,
  input  logic [`ADDR_W-1:0] wr_j1,
  input  logic [`ADDR_W-1:0] wr_j2,
  input  logic [`ADDR_W-1:0] wr_j3,
  input  logic [`ADDR_W-1:0] wr_j4,
  input  logic               host_req_valid,
  output logic               host_req_ready,
  input  mem_pkg::mem_op_e   host_req_op,
  input  logic [`ADDR_W-1:0] host_req_addr,
  input  logic [`DATA_W-1:0] host_req_wdata,
  output logic               host_rsp_valid,
  output logic [`DATA_W-1:0] host_rsp_data,
  output logic               busy,
  output logic               done
);

  logic               rd_req_valid, rd_req_ready, rd_rsp_valid;
  mem_pkg::mem_op_e   rd_req_op;
  logic [`ADDR_W-1:0] rd_req_addr;
  logic [`DATA_W-1:0] rd_rsp_data;
  logic               wr_req_valid, wr_req_ready;
  mem_pkg::mem_op_e   wr_req_op;
  logic [`ADDR_W-1:0] wr_req_addr;
  logic [`DATA_W-1:0] wr_req_wdata;
  logic               s_valid, s_ready;
  logic [`DATA_W-1:0] s_data;
  logic               mem_en, mem_we;
  logic [`ADDR_W-1:0] mem_addr;
  logic [`DATA_W-1:0] mem_wdata, mem_rdata;

  // Reader may idle before the writer's last write, so hold it off while busy
  stream_reader u_reader (
    .clk (clk), .rst (rst), .start (start && !busy), .xfer_count (xfer_count),
    .base (rd_base), .l1 (rd_l1), .l2 (rd_l2), .l3 (rd_l3), .l4 (rd_l4),
    .j0 (rd_j0), .j1 (rd_j1), .j2 (rd_j2), .j3 (rd_j3), .j4 (rd_j4),
    .req_valid (rd_req_valid), .req_ready (rd_req_ready), .req_op (rd_req_op),
    .req_addr (rd_req_addr), .rsp_valid (rd_rsp_valid), .rsp_data (rd_rsp_data),
    .s_valid (s_valid), .s_ready (s_ready), .s_data (s_data)
  );

  stream_writer u_writer (
    .clk (clk), .rst (rst), .start (start), .xfer_count (xfer_count),
    .base (wr_base), .l1 (wr_l1), .l2 (wr_l2), .l3 (wr_l3), .l4 (wr_l4),
    .j0 (wr_j0), .j1 (wr_j1), .j2 (wr_j2), .j3 (wr_j3), .j4 (wr_j4),
    .s_valid (s_valid), .s_ready (s_ready), .s_data (s_data),
    .req_valid (wr_req_valid), .req_ready (wr_req_ready), .req_op (wr_req_op),
    .req_addr (wr_req_addr), .req_wdata (wr_req_wdata),
    .busy (busy), .done (done)
  );

  mem_arbiter u_arb (
    .clk (clk), .rst (rst),
    .host_req_valid (host_req_valid), .host_req_ready (host_req_ready),
    .host_req_op (host_req_op), .host_req_addr (host_req_addr),
    .host_req_wdata (host_req_wdata), .host_rsp_valid (host_rsp_valid),
    .host_rsp_data (host_rsp_data),
    .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready),
    .rd_req_op (rd_req_op), .rd_req_addr (rd_req_addr),
    .rd_req_wdata ('0),                // Reader never writes
    .rd_rsp_valid (rd_rsp_valid), .rd_rsp_data (rd_rsp_data),
    .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready),
    .wr_req_op (wr_req_op), .wr_req_addr (wr_req_addr),
    .wr_req_wdata (wr_req_wdata),
    .wr_rsp_valid (), .wr_rsp_data (),  // Writer takes no read data
    .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
  );

  sram_sp u_sram (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// Round-robin arbiter putting host, reader and writer on one SRAM port
// Grants one requester per cycle and routes read data back a cycle later
`default_nettype none
`include "agu_consts.svh"

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               host_req_valid,
  output logic               host_req_ready,
  input  mem_pkg::mem_op_e   host_req_op,
  input  logic [`ADDR_W-1:0] host_req_addr,
  input  logic [`DATA_W-1:0] host_req_wdata,
  output logic               host_rsp_valid,
  output logic [`DATA_W-1:0] host_rsp_data,
  input  logic               rd_req_valid,
  output logic               rd_req_ready,
  input  mem_pkg::mem_op_e   rd_req_op,
  input  logic [`ADDR_W-1:0] rd_req_addr,
  input  logic [`DATA_W-1:0] rd_req_wdata,
  output logic               rd_rsp_valid,
  output logic [`DATA_W-1:0] rd_rsp_data,
  input  logic               wr_req_valid,
  output logic               wr_req_ready,
  input  mem_pkg::mem_op_e   wr_req_op,
  input  logic [`ADDR_W-1:0] wr_req_addr,
  input  logic [`DATA_W-1:0] wr_req_wdata,
  output logic               wr_rsp_valid,
  output logic [`DATA_W-1:0] wr_rsp_data,
  output logic               mem_en,
  output logic               mem_we,
  output logic [`ADDR_W-1:0] mem_addr,
  output logic [`DATA_W-1:0] mem_wdata,
  input  logic [`DATA_W-1:0] mem_rdata
);

  logic [2:0]        vld;       // Indexed by req_id_e
  mem_pkg::req_id_e  last;      // Most recent winner
  mem_pkg::req_id_e  win;
  logic              any;
  mem_pkg::mem_op_e  win_op;
  logic              rsp_pend;  // Read issued last cycle
  mem_pkg::req_id_e  rsp_id;    // Who issued it

  assign vld = {wr_req_valid, rd_req_valid, host_req_valid};

  // Search starts just past the last winner; nearest valid wins
  always_comb begin
    int idx;
    win = mem_pkg::REQ_HOST;
    any = 1'b0;
    for (int i = 3; i >= 1; i--) begin
      idx = (int'(last) + i) % 3;
      if (vld[idx]) begin
        win = mem_pkg::req_id_e'(idx);
        any = 1'b1;
      end
    end
  end

  assign host_req_ready = any && (win == mem_pkg::REQ_HOST);
  assign rd_req_ready   = any && (win == mem_pkg::REQ_RD);
  assign wr_req_ready   = any && (win == mem_pkg::REQ_WR);

  always_comb begin
    case (win)
      mem_pkg::REQ_RD: begin
        win_op    = rd_req_op;
        mem_addr  = rd_req_addr;
        mem_wdata = rd_req_wdata;
      end
      mem_pkg::REQ_WR: begin
        win_op    = wr_req_op;
        mem_addr  = wr_req_addr;
        mem_wdata = wr_req_wdata;
      end
      default: begin
        win_op    = host_req_op;
        mem_addr  = host_req_addr;
        mem_wdata = host_req_wdata;
      end
    endcase
  end

  assign mem_en = any;
  assign mem_we = any && (win_op == mem_pkg::OP_WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      last     <= mem_pkg::REQ_WR;  // Host is first in line
      rsp_pend <= 1'b0;
    end else begin
      if (any) last <= win;
      rsp_pend <= mem_en && !mem_we;
    end
  end

  always_ff @(posedge clk) begin
    rsp_id <= win;                  // Only looked at with rsp_pend
  end

  // Data fans out to all and only the owner sees valid
  assign host_rsp_valid = rsp_pend && (rsp_id == mem_pkg::REQ_HOST);
  assign rd_rsp_valid   = rsp_pend && (rsp_id == mem_pkg::REQ_RD);
  assign wr_rsp_valid   = rsp_pend && (rsp_id == mem_pkg::REQ_WR);
  assign host_rsp_data  = mem_rdata;
  assign rd_rsp_data    = mem_rdata;
  assign wr_rsp_data    = mem_rdata;

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
// Types describing the shared SRAM bus
// Used by the arbiter, the bus peers and the testbench
`default_nettype none

package mem_pkg;

  // Request operation
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

  // Requester identity that doubles as the round-robin pointer value
  typedef enum logic [1:0] {
    REQ_HOST,
    REQ_RD,
    REQ_WR
  } req_id_e;

endpackage

`default_nettype wire

// ==== src/sram_sp.sv ====
// Single-port synchronous SRAM model with one access per cycle
// Read data appears the cycle after a read enable
`default_nettype none
`include "agu_consts.svh"

module sram_sp (
  input  logic               clk,
  input  logic               en,     // Access this cycle
  input  logic               we,     // Write when set, else read
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] wdata,
  output logic [`DATA_W-1:0] rdata
);

  logic [`DATA_W-1:0] mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];          // One-cycle read latency
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/stream_reader.sv ====
// Source side of the copy that reads words along its AGU pattern
// and hands them on as a valid/ready stream through a two-entry buffer
`default_nettype none
`include "agu_consts.svh"

module stream_reader (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic [`ADDR_W:0]   xfer_count,  // Words to move
  input  logic [`ADDR_W-1:0] base,
  input  logic [`LEN_W-1:0]  l1,
  input  logic [`LEN_W-1:0]  l2,
  input  logic [`LEN_W-1:0]  l3,
  input  logic [`LEN_W-1:0]  l4,
  input  logic [`ADDR_W-1:0] j0,
  input  logic [`ADDR_W-1:0] j1,
  input  logic [`ADDR_W-1:0] j2,
  input  logic [`ADDR_W-1:0] j3,
  input  logic [`ADDR_W-1:0] j4,
  output logic               req_valid,
  input  logic               req_ready,
  output mem_pkg::mem_op_e   req_op,
  output logic [`ADDR_W-1:0] req_addr,
  input  logic               rsp_valid,
  input  logic [`DATA_W-1:0] rsp_data,
  output logic               s_valid,
  input  logic               s_ready,
  output logic [`DATA_W-1:0] s_data
);

  agu_pkg::copy_state_e state;
  logic [`ADDR_W:0]     left;          // Reads still to issue
  logic [1:0]           occ;           // In flight plus buffered
  logic [1:0]           buf_cnt;       // Buffered only
  logic [`DATA_W-1:0]   buf_q [2];
  logic                 wp, rp;
  logic                 rd_fire, pop, agu_clr;
  logic [`ADDR_W-1:0]   agu_addr;

  assign agu_clr   = start && (state == agu_pkg::CP_IDLE);
  assign req_valid = (state == agu_pkg::CP_RUN) && (left != '0) && (occ != 2'd2);
  assign req_op    = mem_pkg::OP_READ;
  assign req_addr  = base + agu_addr;  // Wraps at MEM_DEPTH
  assign rd_fire   = req_valid && req_ready;
  assign s_valid   = buf_cnt != '0;
  assign s_data    = buf_q[rp];
  assign pop       = s_valid && s_ready;

  agu u_agu (
    .clk  (clk),
    .rst  (rst),
    .clr  (agu_clr),
    .step (rd_fire),
    .l1   (l1),
    .l2   (l2),
    .l3   (l3),
    .l4   (l4),
    .j0   (j0),
    .j1   (j1),
    .j2   (j2),
    .j3   (j3),
    .j4   (j4),
    .addr (agu_addr)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= agu_pkg::CP_IDLE;
      left    <= '0;
      occ     <= '0;
      buf_cnt <= '0;
      wp      <= 1'b0;
      rp      <= 1'b0;
    end else begin
      if (agu_clr) begin
        state <= agu_pkg::CP_RUN;
        left  <= xfer_count;
      end else if (state == agu_pkg::CP_RUN && left == '0 && occ == '0) begin
        state <= agu_pkg::CP_IDLE;     // All words handed on
      end
      if (rd_fire) left <= left - 1'b1;
      occ     <= occ + {1'b0, rd_fire} - {1'b0, pop};
      buf_cnt <= buf_cnt + {1'b0, rsp_valid} - {1'b0, pop};
      if (rsp_valid) wp <= ~wp;
      if (pop) rp <= ~rp;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) buf_q[wp] <= rsp_data;  // Slot reserved at issue
  end

endmodule

`default_nettype wire

// ==== src/stream_writer.sv ====
// Destination side of the copy that takes stream words one at a time
// and writes each at its AGU address; owns busy and done
`default_nettype none
`include "agu_consts.svh"

module stream_writer (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic [`ADDR_W:0]   xfer_count,
  input  logic [`ADDR_W-1:0] base,
  input  logic [`LEN_W-1:0]  l1,
  input  logic [`LEN_W-1:0]  l2,
  input  logic [`LEN_W-1:0]  l3,
  input  logic [`LEN_W-1:0]  l4,
  input  logic [`ADDR_W-1:0] j0,
  input  logic [`ADDR_W-1:0] j1,
  input  logic [`ADDR_W-1:0] j2,
  input  logic [`ADDR_W-1:0] j3,
  input  logic [`ADDR_W-1:0] j4,
  input  logic               s_valid,
  output logic               s_ready,
  input  logic [`DATA_W-1:0] s_data,
  output logic               req_valid,
  input  logic               req_ready,
  output mem_pkg::mem_op_e   req_op,
  output logic [`ADDR_W-1:0] req_addr,
  output logic [`DATA_W-1:0] req_wdata,
  output logic               busy,
  output logic               done
);

  agu_pkg::copy_state_e state;
  logic [`ADDR_W:0]     left;       // Writes still to complete
  logic                 pend;       // Word held for writing
  logic [`DATA_W-1:0]   data_q;
  logic                 agu_clr, wr_fire;
  logic [`ADDR_W-1:0]   agu_addr;

  assign agu_clr   = start && (state == agu_pkg::CP_IDLE);
  assign s_ready   = (state == agu_pkg::CP_RUN) && !pend;
  assign req_valid = pend;
  assign req_op    = mem_pkg::OP_WRITE;
  assign req_addr  = base + agu_addr;
  assign req_wdata = data_q;
  assign wr_fire   = req_valid && req_ready;
  assign busy      = state == agu_pkg::CP_RUN;

  agu u_agu (
    .clk  (clk),
    .rst  (rst),
    .clr  (agu_clr),
    .step (wr_fire),
    .l1   (l1),
    .l2   (l2),
    .l3   (l3),
    .l4   (l4),
    .j0   (j0),
    .j1   (j1),
    .j2   (j2),
    .j3   (j3),
    .j4   (j4),
    .addr (agu_addr)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= agu_pkg::CP_IDLE;
      left  <= '0;
      pend  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;                    // Single-cycle pulse
      if (agu_clr) begin
        left <= xfer_count;
        if (xfer_count == '0) done <= 1'b1;  // Nothing to move
        else state <= agu_pkg::CP_RUN;
      end
      if (s_valid && s_ready) pend <= 1'b1;
      if (wr_fire) begin
        pend <= 1'b0;
        left <= left - 1'b1;
        if (left == 1) begin           // Final word accepted
          state <= agu_pkg::CP_IDLE;
          done  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) data_q <= s_data;
  end

endmodule

`default_nettype wire
